// ==== rv_fetch_defs.svh ====
`ifndef RV_FETCH_DEFS_SVH
`define RV_FETCH_DEFS_SVH

// byte address width of the 1 KiB unified memory
`define MEM_AW 10

// width of one memory byte lane
`define BYTE_W 8

// instruction word width
`define INST_W 32

// direct-mapped icache with one instruction word per line
`define ICACHE_LINES 16

// pc after reset
`define RESET_PC {`MEM_AW{1'b0}}

// opcode bit shared by branch, jal, jalr and system
`define OPC_CTRL_BIT 6

`endif

// ==== fetch_pkg.sv ====
`include "rv_fetch_defs.svh"

package fetch_pkg;

    // stall bus from the port controller
    typedef struct packed {
        logic if_hold;
        logic port_busy;
        logic id_hold;
    } stall_t;

    // one request on the byte port
    typedef struct packed {
        logic [`MEM_AW-1:0] addr;
        logic               we;
        logic [`BYTE_W-1:0] wdata;
    } mem_req_t;

    // icache fill
    typedef struct packed {
        logic               we;
        logic [`MEM_AW-1:0] addr;
        logic [`INST_W-1:0] word;
    } icache_wr_t;

    // instruction handed to decode
    typedef struct packed {
        logic               valid;
        logic [`MEM_AW-1:0] pc;
        logic [`INST_W-1:0] inst;
    } fetch_out_t;

endpackage

// ==== byte_mem.sv ====
`include "rv_fetch_defs.svh"

module byte_mem (
    input  logic                clk,
    input  fetch_pkg::mem_req_t req_i,
    output logic [`BYTE_W-1:0]  rdata_o
);

    localparam int unsigned DEPTH = 1 << `MEM_AW;

    logic [`BYTE_W-1:0] mem [0:DEPTH-1];

    // single write port
    always_ff @(posedge clk) begin
        if (req_i.we) begin
            mem[req_i.addr] <= req_i.wdata;
        end
    end

    // read data shows up the cycle after the address
    always_ff @(posedge clk) begin
        rdata_o <= mem[req_i.addr];
    end

endmodule

// ==== mem_port_ctrl.sv ====
`include "rv_fetch_defs.svh"

module mem_port_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  fetch_pkg::mem_req_t load_i,
    input  fetch_pkg::mem_req_t data_req_i,
    input  logic                data_valid_i,
    input  logic [`MEM_AW-1:0]  fetch_addr_i,
    input  logic                branch_wait_i,
    input  logic                id_hold_i,
    output fetch_pkg::mem_req_t mem_req_o,
    output fetch_pkg::stall_t   stall_o
);

    logic port_taken;
    logic port_taken_q;

    // load and data side both push fetch off the port
    assign port_taken = load_i.we | data_valid_i;

    // load first, then data side, then fetch
    always_comb begin
        if (load_i.we) begin
            mem_req_o = load_i;
        end else if (data_valid_i) begin
            mem_req_o = data_req_i;
        end else begin
            mem_req_o.addr  = fetch_addr_i;
            mem_req_o.we    = 1'b0;
            mem_req_o.wdata = '0;
        end
    end

    // byte returned after a taken cycle is not fetch's
    always_ff @(posedge clk) begin
        if (rst) begin
            port_taken_q <= 1'b0;
        end else begin
            port_taken_q <= port_taken;
        end
    end

    always_comb begin
        stall_o.port_busy = port_taken | port_taken_q;
        stall_o.if_hold   = port_taken | port_taken_q | branch_wait_i;
        stall_o.id_hold   = id_hold_i;
    end

endmodule

// ==== inst_cache.sv ====
`include "rv_fetch_defs.svh"

module inst_cache (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [`MEM_AW-1:0]    raddr_i,
    output logic                  hit_o,
    output logic [`INST_W-1:0]    rinst_o,
    input  fetch_pkg::icache_wr_t wr_i
);

    localparam int IDX_W = $clog2(`ICACHE_LINES);
    localparam int TAG_W = `MEM_AW - IDX_W - 2;

    logic [`ICACHE_LINES-1:0] valid_q;
    logic [TAG_W-1:0]         tag_q  [0:`ICACHE_LINES-1];
    logic [`INST_W-1:0]       data_q [0:`ICACHE_LINES-1];

    logic [IDX_W-1:0] rd_idx;
    logic [TAG_W-1:0] rd_tag;
    logic [IDX_W-1:0] wr_idx;
    logic [TAG_W-1:0] wr_tag;

    // word index from the low bits and tag from the rest
    assign rd_idx = raddr_i[IDX_W+1:2];
    assign rd_tag = raddr_i[`MEM_AW-1:IDX_W+2];
    assign wr_idx = wr_i.addr[IDX_W+1:2];
    assign wr_tag = wr_i.addr[`MEM_AW-1:IDX_W+2];

    assign hit_o   = valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
    assign rinst_o = data_q[rd_idx];

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (wr_i.we) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_i.we) begin
            tag_q[wr_idx]  <= wr_tag;
            data_q[wr_idx] <= wr_i.word;
        end
    end

endmodule

// ==== fetch_stage.sv ====
`include "rv_fetch_defs.svh"

module fetch_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  fetch_pkg::stall_t     stall_i,
    input  logic [`BYTE_W-1:0]    mem_rdata_i,
    input  logic                  cache_hit_i,
    input  logic [`INST_W-1:0]    cache_inst_i,
    input  logic                  branch_valid_i,
    input  logic [`MEM_AW-1:0]    branch_addr_i,
    output logic [`MEM_AW-1:0]    mem_addr_o,
    output logic [`MEM_AW-1:0]    cache_raddr_o,
    output fetch_pkg::icache_wr_t cache_wr_o,
    output logic                  branch_wait_o,
    output fetch_pkg::fetch_out_t fetch_o
);

    // byteN captures the byte at pc+N and assemble takes pc+3
    typedef enum logic [3:0] {
        S_IDLE,
        S_LOOKUP,
        S_BYTE0,
        S_BYTE1,
        S_BYTE2,
        S_ASSEMBLE,
        S_WAIT0,
        S_ISSUE0,
        S_WAIT1,
        S_ISSUE1,
        S_WAIT2,
        S_ISSUE2
    } state_e;

    state_e             state_q;
    logic [`MEM_AW-1:0] pc_q;
    logic [`BYTE_W-1:0] byte0_q;
    logic [`BYTE_W-1:0] byte1_q;
    logic [`BYTE_W-1:0] byte2_q;
    logic [`INST_W-1:0] miss_word;
    logic               deliver;
    logic [`INST_W-1:0] deliver_inst;

    // little-endian with the last byte straight off the port
    assign miss_word = {mem_rdata_i, byte2_q, byte1_q, byte0_q};

    assign deliver = !stall_i.id_hold &&
                     ((state_q == S_LOOKUP && cache_hit_i) ||
                      (state_q == S_ASSEMBLE && !stall_i.port_busy));
    assign deliver_inst = (state_q == S_LOOKUP) ? cache_inst_i : miss_word;

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q       <= S_IDLE;
            pc_q          <= `RESET_PC;
            mem_addr_o    <= `RESET_PC;
            cache_raddr_o <= `RESET_PC;
            branch_wait_o <= 1'b0;
            fetch_o.valid <= 1'b0;
            cache_wr_o.we <= 1'b0;
        end else begin
            fetch_o.valid <= 1'b0;
            cache_wr_o.we <= 1'b0;
            if (branch_valid_i && !stall_i.port_busy) begin
                // redirect drops whatever is in flight
                pc_q          <= branch_addr_i;
                mem_addr_o    <= branch_addr_i;
                cache_raddr_o <= branch_addr_i;
                branch_wait_o <= 1'b0;
                state_q       <= S_IDLE;
            end else if (deliver) begin
                fetch_o.valid <= 1'b1;
                fetch_o.pc    <= pc_q;
                fetch_o.inst  <= deliver_inst;
                if (state_q == S_ASSEMBLE) begin
                    cache_wr_o.we   <= 1'b1;
                    cache_wr_o.addr <= pc_q;
                    cache_wr_o.word <= miss_word;
                end
                // a control-flow opcode holds the pc until redirect
                if (deliver_inst[`OPC_CTRL_BIT]) begin
                    branch_wait_o <= 1'b1;
                end else begin
                    pc_q <= pc_q + `MEM_AW'd4;
                end
                state_q <= S_IDLE;
            end else begin
                case (state_q)
                    S_IDLE: begin
                        if (!stall_i.if_hold) begin
                            mem_addr_o    <= pc_q;
                            cache_raddr_o <= pc_q;
                            state_q       <= S_LOOKUP;
                        end
                    end
                    S_LOOKUP: begin
                        // a held hit just stays here
                        if (!cache_hit_i) begin
                            mem_addr_o <= pc_q + `MEM_AW'd1;
                            state_q    <= S_BYTE0;
                        end
                    end
                    S_BYTE0: begin
                        if (stall_i.port_busy) begin
                            state_q <= S_WAIT0;
                        end else begin
                            byte0_q    <= mem_rdata_i;
                            mem_addr_o <= pc_q + `MEM_AW'd2;
                            state_q    <= S_BYTE1;
                        end
                    end
                    S_BYTE1: begin
                        if (stall_i.port_busy) begin
                            state_q <= S_WAIT1;
                        end else begin
                            byte1_q    <= mem_rdata_i;
                            mem_addr_o <= pc_q + `MEM_AW'd3;
                            state_q    <= S_BYTE2;
                        end
                    end
                    S_BYTE2: begin
                        if (stall_i.port_busy) begin
                            state_q <= S_WAIT2;
                        end else begin
                            byte2_q <= mem_rdata_i;
                            state_q <= S_ASSEMBLE;
                        end
                    end
                    S_ASSEMBLE: begin
                        // lost byte3 is refetched behind byte2
                        if (stall_i.port_busy) begin
                            state_q <= S_WAIT2;
                        end
                    end
                    S_WAIT0: begin
                        if (!stall_i.port_busy) begin
                            mem_addr_o <= pc_q;
                            state_q    <= S_ISSUE0;
                        end
                    end
                    S_ISSUE0: begin
                        mem_addr_o <= pc_q + `MEM_AW'd1;
                        state_q    <= S_BYTE0;
                    end
                    S_WAIT1: begin
                        if (!stall_i.port_busy) begin
                            mem_addr_o <= pc_q + `MEM_AW'd1;
                            state_q    <= S_ISSUE1;
                        end
                    end
                    S_ISSUE1: begin
                        mem_addr_o <= pc_q + `MEM_AW'd2;
                        state_q    <= S_BYTE1;
                    end
                    S_WAIT2: begin
                        if (!stall_i.port_busy) begin
                            mem_addr_o <= pc_q + `MEM_AW'd2;
                            state_q    <= S_ISSUE2;
                        end
                    end
                    S_ISSUE2: begin
                        mem_addr_o <= pc_q + `MEM_AW'd3;
                        state_q    <= S_BYTE2;
                    end
                    default: begin
                        state_q <= S_IDLE;
                    end
                endcase
            end
        end
    end

endmodule

// ==== fetch_top.sv ====
`include "rv_fetch_defs.svh"

module fetch_top (
    input  logic                  clk,
    input  logic                  rst,
    input  fetch_pkg::mem_req_t   load_i,
    input  fetch_pkg::mem_req_t   data_req_i,
    input  logic                  data_valid_i,
    output logic [`BYTE_W-1:0]    data_rdata_o,
    input  logic                  id_hold_i,
    input  logic                  branch_valid_i,
    input  logic [`MEM_AW-1:0]    branch_addr_i,
    output fetch_pkg::fetch_out_t fetch_o,
    output logic                  branch_wait_o
);

    fetch_pkg::mem_req_t   mem_req;
    fetch_pkg::stall_t     stall;
    fetch_pkg::icache_wr_t cache_wr;
    logic [`MEM_AW-1:0]    fetch_addr;
    logic [`MEM_AW-1:0]    cache_raddr;
    logic                  cache_hit;
    logic [`INST_W-1:0]    cache_inst;

    // memory read data is shared by fetch and the data side
    byte_mem u_mem (
        .clk     (clk),
        .req_i   (mem_req),
        .rdata_o (data_rdata_o)
    );

    mem_port_ctrl u_port (
        .clk           (clk),
        .rst           (rst),
        .load_i        (load_i),
        .data_req_i    (data_req_i),
        .data_valid_i  (data_valid_i),
        .fetch_addr_i  (fetch_addr),
        .branch_wait_i (branch_wait_o),
        .id_hold_i     (id_hold_i),
        .mem_req_o     (mem_req),
        .stall_o       (stall)
    );

    inst_cache u_icache (
        .clk     (clk),
        .rst     (rst),
        .raddr_i (cache_raddr),
        .hit_o   (cache_hit),
        .rinst_o (cache_inst),
        .wr_i    (cache_wr)
    );

    fetch_stage u_fetch (
        .clk            (clk),
        .rst            (rst),
        .stall_i        (stall),
        .mem_rdata_i    (data_rdata_o),
        .cache_hit_i    (cache_hit),
        .cache_inst_i   (cache_inst),
        .branch_valid_i (branch_valid_i),
        .branch_addr_i  (branch_addr_i),
        .mem_addr_o     (fetch_addr),
        .cache_raddr_o  (cache_raddr),
        .cache_wr_o     (cache_wr),
        .branch_wait_o  (branch_wait_o),
        .fetch_o        (fetch_o)
    );

endmodule

// ==== tb_fetch.sv ====
`include "rv_fetch_defs.svh"

module tb_fetch;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int CLK_PERIOD  = 40;
    localparam int PROG_BYTES  = 128;
    localparam int BR_PC       = 20;
    localparam int MISS_CYCLES = 10;
    localparam int N_DELIV     = 15;
    localparam int MARGIN_CYC  = 400;
    localparam int WATCHDOG_NS = CLK_PERIOD * (40 * N_DELIV + MARGIN_CYC);
    localparam logic [31:0]          SEED      = 32'hfbfa_3843;
    localparam logic [31:0]          CTRL_MASK = 32'h0000_0040;
    localparam logic [`MEM_AW-1:0]   MISS_PC   = `MEM_AW'd64;
    localparam logic [`MEM_AW-1:0]   DATA_ADDR = `MEM_AW'd13;

    logic                  clk;
    logic                  rst;
    fetch_pkg::mem_req_t   load_req;
    fetch_pkg::mem_req_t   data_req;
    logic                  data_valid;
    logic [`BYTE_W-1:0]    data_rdata;
    logic                  id_hold;
    logic                  branch_valid;
    logic [`MEM_AW-1:0]    branch_addr;
    fetch_pkg::fetch_out_t fetch_out;
    logic                  branch_wait;

    logic [`BYTE_W-1:0] model [0:(1 << `MEM_AW)-1];

    fetch_top DUT (
        .clk            (clk),
        .rst            (rst),
        .load_i         (load_req),
        .data_req_i     (data_req),
        .data_valid_i   (data_valid),
        .data_rdata_o   (data_rdata),
        .id_hold_i      (id_hold),
        .branch_valid_i (branch_valid),
        .branch_addr_i  (branch_addr),
        .fetch_o        (fetch_out),
        .branch_wait_o  (branch_wait)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic fail_and_stop();
        $display("Test failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("error: time %0t: %s is %h, expected %h", $time, what, got, exp);
            fail_and_stop();
        end
    endtask

    // little-endian word from the byte model
    function automatic logic [31:0] model_word(input logic [`MEM_AW-1:0] a);
        return {model[a + `MEM_AW'd3], model[a + `MEM_AW'd2],
                model[a + `MEM_AW'd1], model[a]};
    endfunction

    task automatic wait_delivery(input int max_cycles);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!fetch_out.valid && n < max_cycles);
        if (!fetch_out.valid) begin
            $display("no instruction was delivered within %0d cycles", max_cycles);
            fail_and_stop();
        end
    endtask

    task automatic check_delivery(input logic [`MEM_AW-1:0] exp_pc);
        check_value("fetch pc", 32'(fetch_out.pc), 32'(exp_pc));
        check_value("fetch inst", fetch_out.inst, model_word(exp_pc));
    endtask

    task automatic redirect_pc(input logic [`MEM_AW-1:0] target);
        @(negedge clk);
        branch_valid = 1'b1;
        branch_addr  = target;
        @(negedge clk);
        branch_valid = 1'b0;
    endtask

    // every word misses on the first pass
    task automatic cold_fetch();
        for (int i = 0; i <= BR_PC; i += 4) begin
            wait_delivery(MISS_CYCLES);
            check_delivery(`MEM_AW'(i));
        end
    endtask

    task automatic branch_hold(input logic [`MEM_AW-1:0] target);
        check_value("branch_wait", 32'(branch_wait), 32'd1);
        repeat (20) begin
            @(negedge clk);
            check_value("valid during branch wait", 32'(fetch_out.valid), 32'd0);
        end
        redirect_pc(target);
        wait_delivery(2);
        check_delivery(target);
    endtask

    task automatic cache_hits();
        for (int i = 4; i <= BR_PC; i += 4) begin
            wait_delivery(2);
            check_delivery(`MEM_AW'(i));
        end
        check_value("branch_wait after hit", 32'(branch_wait), 32'd1);
    endtask

    task automatic data_interrupt();
        redirect_pc(MISS_PC);
        // lookup and then the first byte phase
        repeat (2) @(negedge clk);
        data_req.addr = DATA_ADDR;
        data_req.we   = 1'b0;
        data_valid    = 1'b1;
        repeat (3) begin
            @(negedge clk);
            check_value("data read", 32'(data_rdata), 32'(model[DATA_ADDR]));
        end
        data_valid = 1'b0;
        wait_delivery(20);
        check_delivery(MISS_PC);
    endtask

    task automatic back_pressure();
        id_hold = 1'b1;
        repeat (15) begin
            @(negedge clk);
            check_value("valid under id_hold", 32'(fetch_out.valid), 32'd0);
        end
        id_hold = 1'b0;
        wait_delivery(2);
        check_delivery(MISS_PC + `MEM_AW'd4);
        wait_delivery(MISS_CYCLES);
        check_delivery(MISS_PC + `MEM_AW'd8);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the tests finished");
        fail_and_stop();
    end

    initial begin
        logic [`MEM_AW-1:0] addr;
        logic [31:0]        word;
        clk          = 1'b0;
        rst          = 1'b1;
        load_req     = '0;
        data_req     = '0;
        data_valid   = 1'b0;
        id_hold      = 1'b0;
        branch_valid = 1'b0;
        branch_addr  = '0;
        void'($urandom(SEED));
        for (int w = 0; w < PROG_BYTES / 4; w++) begin
            word = $urandom() & ~CTRL_MASK;
            if (w == BR_PC / 4) begin
                word = word | CTRL_MASK;
            end
            addr = `MEM_AW'(w * 4);
            model[addr]              = word[7:0];
            model[addr + `MEM_AW'd1] = word[15:8];
            model[addr + `MEM_AW'd2] = word[23:16];
            model[addr + `MEM_AW'd3] = word[31:24];
        end
        repeat (10) @(negedge clk);
        rst = 1'b0;
        // the load port keeps fetch idle
        for (int i = 0; i < PROG_BYTES; i++) begin
            addr           = `MEM_AW'(i);
            load_req.we    = 1'b1;
            load_req.addr  = addr;
            load_req.wdata = model[addr];
            @(negedge clk);
        end
        load_req.we = 1'b0;
        cold_fetch();
        branch_hold(`MEM_AW'd0);
        cache_hits();
        data_interrupt();
        back_pressure();
        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+.
fetch_pkg.sv
byte_mem.sv
mem_port_ctrl.sv
inst_cache.sv
fetch_stage.sv
fetch_top.sv
tb_fetch.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing
TOP       = tb_fetch
FILELIST  = all.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^Test completed successfully$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
